//--- logic/noc_router_pkg.sv
package noc_router_pkg;

  localparam int NUM_PORTS      = 5;
  localparam int FIFO_DEPTH     = 4;
  localparam int COORD_WIDTH    = 4;
  localparam int PAYLOAD_WIDTH  = 16;
  localparam int PORT_IDX_WIDTH = 3;
  localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
  localparam int CREDIT_WIDTH   = $clog2(FIFO_DEPTH + 1);

  typedef logic [COORD_WIDTH-1:0]    coord_t;
  typedef logic [PORT_IDX_WIDTH-1:0] port_idx_t;
  typedef logic [NUM_PORTS-1:0]      port_mask_t;
  typedef logic [CREDIT_WIDTH-1:0]   credit_cnt_t;
  typedef logic [FIFO_PTR_WIDTH-1:0] fifo_ptr_t;
  typedef logic [PAYLOAD_WIDTH-1:0]  payload_t;

  // port numbering, shared by routing and crossbar.
  localparam port_idx_t PORT_X_PLUS  = 3'd0;
  localparam port_idx_t PORT_X_MINUS = 3'd1;
  localparam port_idx_t PORT_Y_PLUS  = 3'd2;
  localparam port_idx_t PORT_Y_MINUS = 3'd3;
  localparam port_idx_t PORT_LOCAL   = 3'd4;

  // head flit payload: [7:4] dest x, [3:0] dest y.
  typedef struct packed {
    logic     valid;
    logic     head;
    logic     tail;
    payload_t payload;
  } flit_t;

  typedef enum logic {
    ALLOC_IDLE,
    ALLOC_LOCKED
  } alloc_state_t;

endpackage

//--- logic/noc_input_fifo.sv
`timescale 1ns/100ps

module noc_input_fifo (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  noc_router_pkg::flit_t i_flit,
  input  logic                  i_deq,
  output noc_router_pkg::flit_t o_head,
  output logic                  o_credit
);

  noc_router_pkg::flit_t       in_q;  // input stage, sampled every edge.
  logic                        in_valid_q;
  noc_router_pkg::flit_t       mem [noc_router_pkg::FIFO_DEPTH];
  noc_router_pkg::fifo_ptr_t   wr_ptr;
  noc_router_pkg::fifo_ptr_t   rd_ptr;
  noc_router_pkg::credit_cnt_t count;
  logic                        push;
  logic                        pop;
  logic                        credit_q;

  assign push = in_valid_q;
  assign pop  = i_deq && (count != '0);

  always_ff @(posedge i_clk) begin
    in_q <= i_flit;
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      in_valid_q <= 1'b0;
    end else begin
      in_valid_q <= i_flit.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_q;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == noc_router_pkg::fifo_ptr_t'(noc_router_pkg::FIFO_DEPTH - 1)) ?
                  '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == noc_router_pkg::fifo_ptr_t'(noc_router_pkg::FIFO_DEPTH - 1)) ?
                  '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      credit_q <= pop; // one credit back upstream per dequeued flit.
    end
  end

  always_comb begin
    o_head = mem[rd_ptr];
    if (count == '0) begin
      o_head.valid = 1'b0;
    end
  end

  assign o_credit = credit_q;

endmodule

//--- logic/noc_route_decoder.sv
`timescale 1ns/100ps

module noc_route_decoder (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  noc_router_pkg::coord_t     i_id_x,
  input  noc_router_pkg::coord_t     i_id_y,
  input  noc_router_pkg::flit_t      i_head,
  input  logic                       i_deq,
  output noc_router_pkg::port_mask_t o_request
);

  noc_router_pkg::coord_t    dest_x;
  noc_router_pkg::coord_t    dest_y;
  noc_router_pkg::port_idx_t route_head;
  noc_router_pkg::port_idx_t route_q;
  noc_router_pkg::port_idx_t route;

  assign dest_x = i_head.payload[2*noc_router_pkg::COORD_WIDTH-1:noc_router_pkg::COORD_WIDTH];
  assign dest_y = i_head.payload[noc_router_pkg::COORD_WIDTH-1:0];

  // dimension order: resolve x first, then y.
  always_comb begin
    if (dest_x > i_id_x) begin
      route_head = noc_router_pkg::PORT_X_PLUS;
    end else if (dest_x < i_id_x) begin
      route_head = noc_router_pkg::PORT_X_MINUS;
    end else if (dest_y > i_id_y) begin
      route_head = noc_router_pkg::PORT_Y_PLUS;
    end else if (dest_y < i_id_y) begin
      route_head = noc_router_pkg::PORT_Y_MINUS;
    end else begin
      route_head = noc_router_pkg::PORT_LOCAL;
    end
  end

  // body and tail follow the route taken by their head.
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      route_q <= noc_router_pkg::PORT_LOCAL;
    end else if (i_deq && i_head.valid && i_head.head) begin
      route_q <= route_head;
    end
  end

  assign route = i_head.head ? route_head : route_q;

  always_comb begin
    o_request = '0;
    if (i_head.valid) begin
      o_request[route] = 1'b1;
    end
  end

endmodule

//--- logic/noc_switch_allocator.sv
`timescale 1ns/100ps

module noc_switch_allocator (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  noc_router_pkg::port_mask_t i_request [noc_router_pkg::NUM_PORTS],
  input  noc_router_pkg::port_mask_t i_tail,
  input  noc_router_pkg::port_mask_t i_credit_ok,
  output noc_router_pkg::port_mask_t o_grant [noc_router_pkg::NUM_PORTS],
  output noc_router_pkg::port_mask_t o_deq
);

  localparam int N = noc_router_pkg::NUM_PORTS;

  noc_router_pkg::alloc_state_t state  [N];
  noc_router_pkg::port_idx_t    owner  [N]; // input holding the lock.
  noc_router_pkg::port_idx_t    rr_ptr [N]; // last input served.
  noc_router_pkg::port_idx_t    winner [N];
  noc_router_pkg::port_idx_t    sel    [N];
  noc_router_pkg::port_mask_t   req_col [N]; // requests seen by each output.
  noc_router_pkg::port_mask_t   found;
  noc_router_pkg::port_mask_t   fire;

  always_comb begin
    for (int o = 0; o < N; o++) begin
      for (int i = 0; i < N; i++) begin
        req_col[o][i] = i_request[i][o];
      end
    end
  end

  // round-robin search, starting just after the pointer.
  always_comb begin
    int idx;
    for (int o = 0; o < N; o++) begin
      found[o]  = 1'b0;
      winner[o] = rr_ptr[o];
      for (int k = 1; k <= N; k++) begin
        idx = (int'(rr_ptr[o]) + k) % N;
        if (!found[o] && req_col[o][idx]) begin
          found[o]  = 1'b1;
          winner[o] = noc_router_pkg::port_idx_t'(idx);
        end
      end
    end
  end

  always_comb begin
    for (int o = 0; o < N; o++) begin
      if (state[o] == noc_router_pkg::ALLOC_LOCKED) begin
        sel[o]  = owner[o];
        fire[o] = req_col[o][owner[o]];
      end else begin
        sel[o]  = winner[o];
        fire[o] = found[o];
      end
      fire[o]       = fire[o] && i_credit_ok[o]; // no credit, no grant.
      o_grant[o]    = '0;
      o_grant[o][sel[o]] = fire[o];
    end
  end

  // each input requests one output at most, so grants never collide.
  always_comb begin
    o_deq = '0;
    for (int o = 0; o < N; o++) begin
      o_deq = o_deq | o_grant[o];
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int o = 0; o < N; o++) begin
        state[o]  <= noc_router_pkg::ALLOC_IDLE;
        owner[o]  <= '0;
        rr_ptr[o] <= noc_router_pkg::port_idx_t'(N - 1);
      end
    end else begin
      for (int o = 0; o < N; o++) begin
        if (fire[o]) begin
          if (i_tail[sel[o]]) begin
            state[o]  <= noc_router_pkg::ALLOC_IDLE; // packet done, release.
            rr_ptr[o] <= sel[o];
          end else begin
            state[o] <= noc_router_pkg::ALLOC_LOCKED;
            owner[o] <= sel[o];
          end
        end
      end
    end
  end

endmodule

//--- logic/noc_output_port.sv
`timescale 1ns/100ps

module noc_output_port (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  noc_router_pkg::flit_t i_flit,
  input  logic                  i_credit,
  output logic                  o_credit_ok,
  output noc_router_pkg::flit_t o_flit
);

  logic                        valid_q;
  logic                        head_q;
  logic                        tail_q;
  noc_router_pkg::payload_t    payload_q;
  noc_router_pkg::credit_cnt_t credit_cnt; // free slots downstream.
  logic                        send;

  assign send = i_flit.valid;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= send;
    end
  end

  always_ff @(posedge i_clk) begin
    if (send) begin
      head_q    <= i_flit.head;
      tail_q    <= i_flit.tail;
      payload_q <= i_flit.payload;
    end
  end

  // send and credit return may land in the same cycle.
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      credit_cnt <= noc_router_pkg::credit_cnt_t'(noc_router_pkg::FIFO_DEPTH);
    end else begin
      case ({send, i_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  assign o_credit_ok = (credit_cnt != '0);

  assign o_flit = '{
    valid:   valid_q,
    head:    head_q,
    tail:    tail_q,
    payload: payload_q
  };

endmodule

//--- logic/noc_router.sv
`timescale 1ns/100ps

module noc_router (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  noc_router_pkg::coord_t     i_id_x,
  input  noc_router_pkg::coord_t     i_id_y,
  input  noc_router_pkg::flit_t      i_flit [noc_router_pkg::NUM_PORTS],
  output wire noc_router_pkg::port_mask_t o_credit,
  output noc_router_pkg::flit_t      o_flit [noc_router_pkg::NUM_PORTS],
  input  noc_router_pkg::port_mask_t i_credit
);

  localparam int N = noc_router_pkg::NUM_PORTS;

  noc_router_pkg::flit_t      head      [N]; // fifo heads, by input.
  noc_router_pkg::port_mask_t request   [N];
  noc_router_pkg::port_mask_t grant     [N]; // by output.
  noc_router_pkg::flit_t      xbar_flit [N];
  noc_router_pkg::port_mask_t tail;
  noc_router_pkg::port_mask_t deq;
  wire noc_router_pkg::port_mask_t credit_ok;

  for (genvar p = 0; p < N; p++) begin : g_port
    noc_input_fifo u_fifo (
      .i_clk    (i_clk),
      .i_rst_n  (i_rst_n),
      .i_flit   (i_flit[p]),
      .i_deq    (deq[p]),
      .o_head   (head[p]),
      .o_credit (o_credit[p])
    );

    noc_route_decoder u_decoder (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_id_x    (i_id_x),
      .i_id_y    (i_id_y),
      .i_head    (head[p]),
      .i_deq     (deq[p]),
      .o_request (request[p])
    );

    noc_output_port u_output (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_flit      (xbar_flit[p]),
      .i_credit    (i_credit[p]),
      .o_credit_ok (credit_ok[p]),
      .o_flit      (o_flit[p])
    );
  end

  always_comb begin
    for (int i = 0; i < N; i++) begin
      tail[i] = head[i].tail;
    end
  end

  noc_switch_allocator u_allocator (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_request   (request),
    .i_tail      (tail),
    .i_credit_ok (credit_ok),
    .o_grant     (grant),
    .o_deq       (deq)
  );

  // crossbar. an output with no grant sees an empty flit.
  always_comb begin
    for (int o = 0; o < N; o++) begin
      xbar_flit[o] = '0;
      for (int i = 0; i < N; i++) begin
        if (grant[o][i]) begin
          xbar_flit[o] = head[i];
        end
      end
    end
  end

endmodule

//--- dv/noc_router_properties.sv
`timescale 1ns/100ps

module noc_router_properties (
  input logic                       i_clk,
  input logic                       i_rst_n,
  input noc_router_pkg::flit_t      i_out_flit [noc_router_pkg::NUM_PORTS],
  input noc_router_pkg::port_mask_t i_credit
);

  noc_router_pkg::port_mask_t in_pkt_q; // head seen, tail still to come.
  int                         link_credit_q [noc_router_pkg::NUM_PORTS];

  always_ff @(posedge i_clk) begin
    for (int p = 0; p < noc_router_pkg::NUM_PORTS; p++) begin
      if (!i_rst_n) begin
        in_pkt_q[p]      <= 1'b0;
        link_credit_q[p] <= noc_router_pkg::FIFO_DEPTH;
      end else begin
        if (i_out_flit[p].valid) begin
          in_pkt_q[p] <= !i_out_flit[p].tail;
        end
        case ({i_out_flit[p].valid, i_credit[p]})
          2'b10:   link_credit_q[p] <= link_credit_q[p] - 1;
          2'b01:   link_credit_q[p] <= link_credit_q[p] + 1;
          default: link_credit_q[p] <= link_credit_q[p];
        endcase
      end
    end
  end

  for (genvar p = 0; p < noc_router_pkg::NUM_PORTS; p++) begin : g_check
    // free slots downstream, counted from the link alone.
    a_credit: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_out_flit[p].valid |-> (link_credit_q[p] > 0))
      else $error("output %0d sent a flit with no downstream credit", p);

    a_reset: assert property (@(posedge i_clk)
      $rose(i_rst_n) |-> !i_out_flit[p].valid)
      else $error("output %0d valid right after reset", p);

    a_wormhole: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (i_out_flit[p].valid && i_out_flit[p].head) |-> !in_pkt_q[p])
      else $error("output %0d started a packet before the last one ended", p);
  end

endmodule

bind noc_router noc_router_properties u_properties (
  .i_clk      (i_clk),
  .i_rst_n    (i_rst_n),
  .i_out_flit (o_flit),
  .i_credit   (i_credit)
);

//--- dv/noc_router_tb.sv
`timescale 1ns/100ps

module noc_router_tb;

  localparam int N         = noc_router_pkg::NUM_PORTS;
  localparam int DEPTH     = noc_router_pkg::FIFO_DEPTH;
  localparam int MAX_FLITS = 64;
  localparam int COLS      = 5; // port, head, tail, payload, route.
  localparam noc_router_pkg::coord_t ROUTER_X = 4'd2;
  localparam noc_router_pkg::coord_t ROUTER_Y = 4'd2;

  logic                       i_clk;
  logic                       i_rst_n;
  noc_router_pkg::flit_t      up_flit [N];
  noc_router_pkg::port_mask_t up_credit;
  noc_router_pkg::flit_t      dn_flit [N];
  noc_router_pkg::port_mask_t dn_credit;

  logic [15:0]               stim_mem [COLS*MAX_FLITS];
  noc_router_pkg::flit_t     send_q [N][$];     // per input.
  noc_router_pkg::flit_t     exp_q [N][$];      // per source tag.
  noc_router_pkg::port_idx_t exp_port_q [N][$];
  noc_router_pkg::port_idx_t lock_tag [N];
  logic [N-1:0] locked;
  logic [15:0]  lfsr;
  logic         loaded = 1'b0;
  logic         after_rst = 1'b0;
  int num_flits;
  int delivered = 0;
  int up_cnt [N];
  int sent [N];
  int returned [N];
  int dn_pending [N];
  int dn_granted [N];
  int dn_seen [N];
  int flit_errors = 0;
  int port_errors = 0;
  int other_errors = 0;

  noc_router i_noc_router (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_id_x   (ROUTER_X),
    .i_id_y   (ROUTER_Y),
    .i_flit   (up_flit),
    .o_credit (up_credit),
    .o_flit   (dn_flit),
    .i_credit (dn_credit)
  );

  // xy rule, x resolved before y.
  function automatic noc_router_pkg::port_idx_t xy_route(input noc_router_pkg::flit_t f);
    noc_router_pkg::coord_t dx;
    noc_router_pkg::coord_t dy;
    dx = f.payload[7:4];
    dy = f.payload[3:0];
    if (dx != ROUTER_X) begin
      xy_route = (dx > ROUTER_X) ? 3'd0 : 3'd1;
    end else if (dy != ROUTER_Y) begin
      xy_route = (dy > ROUTER_Y) ? 3'd2 : 3'd3;
    end else begin
      xy_route = 3'd4;
    end
  endfunction

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic check_flit(input noc_router_pkg::flit_t got, input noc_router_pkg::flit_t exp,
                            input string what);
    if (got !== exp) begin
      flit_errors++;
      $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_port(input noc_router_pkg::port_idx_t got,
                            input noc_router_pkg::port_idx_t exp, input string what);
    if (got !== exp) begin
      port_errors++;
      $display("error at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // upstream neighbours, each limited by its own credit count.
  always @(posedge i_clk) begin
    for (int p = 0; p < N; p++) begin
      if (!i_rst_n) begin
        up_flit[p] <= '0;
      end else begin
        if (up_credit[p]) begin
          up_cnt[p]++;
          returned[p]++;
        end
        if (send_q[p].size() > 0 && up_cnt[p] > 0) begin
          up_flit[p] <= send_q[p].pop_front();
          up_cnt[p]--;
          sent[p]++;
        end else begin
          up_flit[p] <= '0;
        end
      end
    end
  end

  // output monitor and downstream neighbours with random credit return.
  always @(posedge i_clk) begin
    logic                      rnd;
    noc_router_pkg::port_idx_t tag;
    for (int o = 0; o < N; o++) begin
      tag = noc_router_pkg::port_idx_t'(dn_flit[o].payload[14:12]);
      if (!after_rst) begin
        if (dn_flit[o].valid || up_credit[o]) begin
          other_errors++;
          $display("flit or credit seen on port %0d during reset", o);
        end
      end else if (dn_flit[o].valid) begin
        delivered++;
        dn_seen[o]++;
        dn_pending[o]++;
        if (dn_seen[o] > DEPTH + dn_granted[o]) begin
          other_errors++;
          $display("error at %0t: output %0d sent more flits than its credits", $time, o);
        end
        if (tag >= N || exp_q[tag].size() == 0) begin
          other_errors++;
          $display("output %0d delivered a flit that was never sent", o);
        end else begin
          check_port(noc_router_pkg::port_idx_t'(o), exp_port_q[tag].pop_front(), "output port");
          check_flit(dn_flit[o], exp_q[tag].pop_front(), "output flit");
        end
        if (locked[o]) begin
          check_port(tag, lock_tag[o], "wormhole source");
        end
        lock_tag[o] = tag;
        locked[o]   = !dn_flit[o].tail;
      end
      rnd = 1'b0;
      if (dn_pending[o] > 0) begin
        rnd  = lfsr[0];
        lfsr = lfsr_next(lfsr);
      end
      dn_credit[o] <= rnd;
      if (rnd) begin
        dn_pending[o]--;
        dn_granted[o]++;
      end
    end
    after_rst <= i_rst_n;
  end

  initial begin
    noc_router_pkg::flit_t     f;
    noc_router_pkg::port_idx_t route [N];
    noc_router_pkg::port_idx_t src;
    int base;
    i_rst_n   = 1'b0;
    dn_credit = '0;
    locked    = '0;
    lfsr      = 16'd34053;
    for (int p = 0; p < N; p++) begin
      up_flit[p] = '0;
      up_cnt[p]  = DEPTH;
      route[p]   = '0;
      {sent[p], returned[p], dn_pending[p], dn_granted[p], dn_seen[p]} = '0;
    end
    $readmemh("dv/noc_router_stim.txt", stim_mem);
    num_flits = 0;
    while (num_flits < MAX_FLITS && !$isunknown(stim_mem[COLS*num_flits])) begin
      base = COLS * num_flits;
      src  = noc_router_pkg::port_idx_t'(stim_mem[base]);
      f    = '{valid: 1'b1, head: stim_mem[base+1][0], tail: stim_mem[base+2][0],
               payload: stim_mem[base+3]};
      if (f.head) begin
        route[src] = xy_route(f); // body and tail keep the head's route.
      end
      check_port(noc_router_pkg::port_idx_t'(stim_mem[base+4]), route[src], "stim route");
      check_port(noc_router_pkg::port_idx_t'(f.payload[14:12]), src, "stim source tag");
      send_q[src].push_back(f);
      exp_q[src].push_back(f);
      exp_port_q[src].push_back(route[src]);
      num_flits++;
    end
    if (num_flits == 0) begin
      other_errors++;
      $display("no flits could be read from the stim file");
    end
    loaded = 1'b1;
    repeat (5) @(posedge i_clk);
    i_rst_n <= 1'b1;
    wait (delivered >= num_flits);
    repeat (2) @(posedge i_clk);
    for (int p = 0; p < N; p++) begin
      if (returned[p] != sent[p] || up_cnt[p] != DEPTH) begin
        other_errors++;
        $display("error at %0t: input %0d returned %0d credits for %0d flits, holds %0d",
                 $time, p, returned[p], sent[p], up_cnt[p]);
      end
    end
    $display("errors: flit %0d, port %0d, other %0d", flit_errors, port_errors, other_errors);
    if (flit_errors + port_errors + other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    repeat (num_flits * 40 + 200) @(posedge i_clk);
    $display("run timed out with %0d of %0d flits delivered", delivered, num_flits);
    $display("errors: flit %0d, port %0d, other %0d", flit_errors, port_errors, other_errors);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- files.f
logic/noc_router_pkg.sv
logic/noc_input_fifo.sv
logic/noc_route_decoder.sv
logic/noc_switch_allocator.sv
logic/noc_output_port.sv
logic/noc_router.sv
dv/noc_router_properties.sv
dv/noc_router_tb.sv

//--- dv/noc_router_stim.txt
// columns: input port, head, tail, payload, expected output port (all hex).
// head payload: [14:12] source tag, [7:4] dest x, [3:0] dest y. router sits at (2,2).
0 1 0 0123 2
0 0 0 0aa1 2
0 0 1 0aa2 2
0 1 1 0232 0
1 1 0 1124 2
1 0 0 1bb1 2
1 0 0 1bb2 2
1 0 1 1bb3 2
1 1 0 1221 3
1 0 1 1bb4 3
2 1 0 2151 0
2 0 1 2cc1 0
2 1 1 2222 4
3 1 0 3102 1
3 0 0 3dd1 1
3 0 1 3dd2 1
3 1 0 3220 3
3 0 1 3dd3 3
4 1 0 4123 2
4 0 1 4ee1 2
4 1 0 4212 1
4 0 0 4ee2 1
4 0 1 4ee3 1
